//--- Bender.yml
package:
  name: sd_link

sources:
  - source/sd_link_pkg.sv
  - source/sd_cmd_decode.sv
  - source/sd_card_execute.sv
  - source/sd_resp_format.sv
  - source/sd_link.sv
  - target: simulation
    files:
      - sim/sd_link_chk.sv
      - sim/sd_link_tb.sv

//--- sd_link.f
source/sd_link_pkg.sv
source/sd_cmd_decode.sv
source/sd_card_execute.sv
source/sd_resp_format.sv
source/sd_link.sv
sim/sd_link_chk.sv
sim/sd_link_tb.sv

//--- sim/sd_link_chk.sv
`timescale 1ns/10ps

module sd_link_chk import sd_link_pkg::*; (
   input logic                    clk_50,
   input logic                    reset_s,
   input logic                    cmd_req,
   input logic                    cmd_ack,
   input logic                    resp_req,
   input logic                    resp_ack,
   input logic [RESP_FRAME_W-1:0] resp_frame
);

   // failed assertions so far
   int unsigned fail_count = 0;

   // ack only answers a request
   cmd_ack_rise: assert property (
      @(posedge clk_50) disable iff (!reset_s)
      $rose(cmd_ack) |-> $past(cmd_req)
   ) else begin
      $error("cmd_ack rose while cmd_req was low");
      fail_count++;
   end

   cmd_ack_fall: assert property (
      @(posedge clk_50) disable iff (!reset_s)
      $fell(cmd_ack) |-> !$past(cmd_req)
   ) else begin
      $error("cmd_ack fell while cmd_req was still high");
      fail_count++;
   end

   // response side waits for the phy
   resp_req_hold: assert property (
      @(posedge clk_50) disable iff (!reset_s)
      resp_req && !resp_ack |=> resp_req
   ) else begin
      $error("resp_req dropped before resp_ack");
      fail_count++;
   end

   resp_frame_hold: assert property (
      @(posedge clk_50) disable iff (!reset_s)
      resp_req && $past(resp_req) |-> $stable(resp_frame)
   ) else begin
      $error("resp_frame changed while resp_req was high");
      fail_count++;
   end

endmodule

//--- sim/sd_link_tb.sv
`timescale 1ns/10ps

module sd_link_tb import sd_link_pkg::*; ();

   localparam int RESET_CYCLES = 10;
   localparam int HS_LIMIT     = 32;
   localparam int CMD_COUNT    = 27;
   localparam int CYCLE_BUDGET = 64;

   logic                    clk_50 = 1'b0;
   logic                    reset_s;
   logic                    cmd_req;
   logic [CMD_FRAME_W-1:0]  cmd_frame;
   logic                    cmd_crc_good;
   logic                    resp_ack;
   logic                    cmd_ack;
   logic                    resp_req;
   logic [RESP_FRAME_W-1:0] resp_frame;
   resp_kind_t              resp_kind;
   card_state_t             card_state;
   logic                    err_cmd_crc;
   logic                    err_unhandled_cmd;

   logic [31:0]             lfsr = 32'hebe0_d296;
   logic [RESP_FRAME_W-1:0] captured_frame;
   logic [15:0]             rca;
   int unsigned             cycle = 0;
   int unsigned             ack_cycle = 0;
   int                      errors = 0;
   int                      test_errors = 0;
   int                      tests_run = 0;

   sd_link sd_link_i (
      .clk_50, .reset_s, .cmd_req, .cmd_frame, .cmd_crc_good, .resp_ack, .cmd_ack,
      .resp_req, .resp_frame, .resp_kind, .card_state, .err_cmd_crc, .err_unhandled_cmd
   );

   bind sd_link sd_link_chk sd_link_chk_i (
      .clk_50, .reset_s, .cmd_req, .cmd_ack, .resp_req, .resp_ack, .resp_frame
   );

   always #10 clk_50 = ~clk_50;

   always @(posedge clk_50) begin
      cycle <= cycle + 1;
   end

   // galois lfsr stepped once per bit taken
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] r;
      r = '0;
      for (int i = 0; i < n; i++) begin
         lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
         r = {r[30:0], lfsr[0]};
      end
      return r;
   endfunction

   function automatic logic [31:0] status_word(input card_state_t st, input logic app,
                                               input logic illegal, input logic crc);
      logic [31:0] s;
      s = 32'h0;
      s[STAT_READY_FOR_DATA]  = 1'b1;
      s[STAT_STATE_LSB +: 4]  = st;
      s[STAT_APP_CMD]         = app;
      s[STAT_ILLEGAL_COMMAND] = illegal;
      s[STAT_COM_CRC_ERROR]   = crc;
      return s;
   endfunction

   // R6 keeps bits 23, 22, 19 and 12:0
   function automatic logic [15:0] short_status(input logic [31:0] s);
      return {s[STAT_COM_CRC_ERROR], s[STAT_ILLEGAL_COMMAND], s[STAT_ERROR], s[12:0]};
   endfunction

   function automatic logic [RESP_FRAME_W-1:0] r1_frame(input logic [5:0] idx,
                                                        input logic [31:0] s);
      return {2'b00, idx, s, 8'h01, 88'h0};
   endfunction

   task automatic note_mismatch(input string msg);
      $display("MISMATCH at %0t: %s", $time, msg);
      errors++;
      test_errors++;
   endtask

   task automatic note_failure(input string msg);
      $display("ERROR at %0t: %s", $time, msg);
      errors++;
      test_errors++;
   endtask

   task automatic end_test(input string name);
      $display("test %-12s finished with %0d errors", name, test_errors);
      tests_run++;
      test_errors = 0;
   endtask

   task automatic start_cmd(input logic [5:0] idx, input logic [31:0] arg, input logic crc_ok);
      @(posedge clk_50);
      cmd_frame    <= {2'b01, idx, arg, 7'h00, 1'b1};
      cmd_crc_good <= crc_ok;
      cmd_req      <= 1'b1;
   endtask

   // phy side of the command handshake after req is up
   task automatic finish_cmd();
      int n;
      n = 0;
      @(posedge clk_50);
      while (!cmd_ack && n < HS_LIMIT) begin
         @(posedge clk_50);
         n++;
      end
      if (!cmd_ack) begin
         note_failure("cmd_ack never rose");
      end
      ack_cycle = cycle;
      cmd_req <= 1'b0;
      n = 0;
      @(posedge clk_50);
      while (cmd_ack && n < HS_LIMIT) begin
         @(posedge clk_50);
         n++;
      end
      if (cmd_ack) begin
         note_failure("cmd_ack stayed high after cmd_req fell");
      end
   endtask

   task automatic send_cmd(input logic [5:0] idx, input logic [31:0] arg, input logic crc_ok);
      start_cmd(idx, arg, crc_ok);
      finish_cmd();
   endtask

   task automatic await_resp(input resp_kind_t kind, input logic [RESP_FRAME_W-1:0] exp,
                             input string what);
      int n;
      n = 0;
      @(posedge clk_50);
      while (!resp_req && n < HS_LIMIT) begin
         @(posedge clk_50);
         n++;
      end
      if (!resp_req) begin
         note_failure($sformatf("no response arrived for %s", what));
      end else begin
         captured_frame = resp_frame;
         if (cycle - ack_cycle != 3) begin
            note_mismatch($sformatf("%s resp_req %0d cycles after cmd_ack, expected 3",
                                    what, cycle - ack_cycle));
         end
         if (resp_kind !== kind) begin
            note_mismatch($sformatf("%s kind %s, expected %s", what, resp_kind.name(),
                                    kind.name()));
         end
         if (resp_frame !== exp) begin
            note_mismatch($sformatf("%s frame %h, expected %h", what, resp_frame, exp));
         end
      end
   endtask

   task automatic ack_resp(input int delay);
      int n;
      repeat (delay) @(posedge clk_50);
      resp_ack <= 1'b1;
      n = 0;
      @(posedge clk_50);
      while (resp_req && n < HS_LIMIT) begin
         @(posedge clk_50);
         n++;
      end
      if (resp_req) begin
         note_failure("resp_req did not fall after resp_ack");
      end
      resp_ack <= 1'b0;
      @(posedge clk_50);
   endtask

   task automatic expect_resp(input resp_kind_t kind, input logic [RESP_FRAME_W-1:0] exp,
                              input string what);
      await_resp(kind, exp, what);
      if (resp_req) begin
         ack_resp(rand_bits(4));
      end
   endtask

   task automatic expect_no_resp(input string what);
      repeat (6) begin
         @(posedge clk_50);
         if (resp_req) begin
            note_failure($sformatf("unexpected response after %s", what));
         end
      end
   endtask

   task automatic check_state(input card_state_t exp, input string what);
      if (card_state !== exp) begin
         note_mismatch($sformatf("%s card_state %s, expected %s", what, card_state.name(),
                                 exp.name()));
      end
   endtask

   task automatic test_init();
      logic [31:0] draw;
      logic [7:0]  check_byte;
      draw       = rand_bits(8);
      check_byte = draw[7:0];
      send_cmd(CMD_IDX_GO_IDLE, 32'h0, 1'b1);
      expect_no_resp("CMD0");
      check_state(CARD_IDLE, "CMD0");
      send_cmd(CMD_IDX_SEND_IF_COND, {20'h0, 4'h1, check_byte}, 1'b1);
      expect_resp(RESP_R7, {2'b00, 6'd8, 20'h0, 4'b0001, check_byte, 8'h01, 88'h0}, "CMD8");
      send_cmd(CMD_IDX_APP_CMD, 32'h0, 1'b1);
      expect_resp(RESP_R1, r1_frame(6'd55, status_word(CARD_IDLE, 1'b1, 1'b0, 1'b0)), "CMD55");
      send_cmd(ACMD_IDX_SEND_OP_COND, {8'h40, OCR_VOLTAGE_WINDOW}, 1'b1);
      expect_resp(RESP_R3, {2'b00, 6'h3F, 32'hC0FF8000, 8'hFF, 88'h0}, "ACMD41");
      check_state(CARD_READY, "ACMD41");
      end_test("init");
   endtask

   task automatic test_ident();
      send_cmd(CMD_IDX_ALL_SEND_CID, 32'h0, 1'b1);
      expect_resp(RESP_R2, {2'b00, 6'h3F, CID_VALUE[127:1], 1'b1}, "CMD2");
      check_state(CARD_IDENT, "CMD2");
      send_cmd(CMD_IDX_SEND_REL_ADDR, 32'h0, 1'b1);
      expect_resp(RESP_R6, {2'b00, 6'd3, 16'h1337,
                            short_status(status_word(CARD_IDENT, 1'b0, 1'b0, 1'b0)),
                            8'h01, 88'h0}, "first CMD3");
      send_cmd(CMD_IDX_SEND_REL_ADDR, 32'h0, 1'b1);
      expect_resp(RESP_R6, {2'b00, 6'd3, 16'h266E,
                            short_status(status_word(CARD_STBY, 1'b0, 1'b0, 1'b0)),
                            8'h01, 88'h0}, "second CMD3");
      check_state(CARD_STBY, "second CMD3");
      rca = 16'h266E;
      end_test("ident");
   endtask

   task automatic test_select();
      logic [31:0] got_status;
      send_cmd(CMD_IDX_SEL_CARD, {rca, 16'h0}, 1'b1);
      expect_resp(RESP_R1B, r1_frame(6'd7, status_word(CARD_STBY, 1'b0, 1'b0, 1'b0)), "CMD7");
      check_state(CARD_TRAN, "CMD7 select");
      send_cmd(CMD_IDX_SEND_STATUS, {rca, 16'h0}, 1'b1);
      expect_resp(RESP_R1, r1_frame(6'd13, status_word(CARD_TRAN, 1'b0, 1'b0, 1'b0)), "CMD13");
      got_status = captured_frame[127:96];
      if (got_status[STAT_STATE_LSB +: 4] !== CARD_TRAN) begin
         note_mismatch($sformatf("CMD13 status state %0d, expected TRAN",
                                 got_status[STAT_STATE_LSB +: 4]));
      end
      // another card's address deselects us
      send_cmd(CMD_IDX_SEL_CARD, {rca ^ 16'h00FF, 16'h0}, 1'b1);
      expect_no_resp("CMD7 deselect");
      check_state(CARD_STBY, "CMD7 deselect");
      end_test("select");
   endtask

   task automatic test_error_cases();
      if (err_cmd_crc !== 1'b0 || err_unhandled_cmd !== 1'b0) begin
         note_mismatch("error flags set before any bad command");
      end
      send_cmd(CMD_IDX_SEND_STATUS, {rca, 16'h0}, 1'b0);
      expect_no_resp("bad CRC frame");
      if (err_cmd_crc !== 1'b1) begin
         note_mismatch("err_cmd_crc not set after bad CRC frame");
      end
      send_cmd(6'd5, 32'h0, 1'b1);
      expect_no_resp("unknown index");
      if (err_unhandled_cmd !== 1'b1) begin
         note_mismatch("err_unhandled_cmd not set after unknown index");
      end
      send_cmd(CMD_IDX_ALL_SEND_CID, 32'h0, 1'b1);
      expect_no_resp("CMD2 in STBY");
      check_state(CARD_STBY, "CMD2 in STBY");
      end_test("errors");
   endtask

   task automatic test_backpressure();
      logic [RESP_FRAME_W-1:0] exp;
      exp = r1_frame(6'd13, status_word(CARD_STBY, 1'b0, 1'b0, 1'b0));
      for (int i = 0; i < 10; i++) begin
         send_cmd(CMD_IDX_SEND_STATUS, {rca, 16'h0}, 1'b1);
         expect_resp(RESP_R1, exp, $sformatf("CMD13 #%0d", i));
      end
      // next command offered while the response is still held
      send_cmd(CMD_IDX_SEND_STATUS, {rca, 16'h0}, 1'b1);
      await_resp(RESP_R1, exp, "held CMD13");
      start_cmd(CMD_IDX_SEND_STATUS, {rca, 16'h0}, 1'b1);
      repeat (8) begin
         @(posedge clk_50);
         if (cmd_ack) begin
            note_failure("cmd_ack rose while a response was pending");
         end
      end
      resp_ack <= 1'b1;
      repeat (6) begin
         @(posedge clk_50);
         if (cmd_ack) begin
            note_failure("cmd_ack rose before resp_ack fell");
         end
      end
      if (resp_req) begin
         note_failure("resp_req still high while resp_ack was held");
      end
      resp_ack <= 1'b0;
      finish_cmd();
      expect_resp(RESP_R1, exp, "CMD13 after held response");
      end_test("backpressure");
   endtask

   task automatic test_inactive();
      send_cmd(CMD_IDX_GO_INACTIVE, {rca, 16'h0}, 1'b1);
      expect_no_resp("CMD15");
      check_state(CARD_INA, "CMD15");
      send_cmd(CMD_IDX_GO_IDLE, 32'h0, 1'b1);
      expect_no_resp("CMD0 in INA");
      check_state(CARD_INA, "CMD0 in INA");
      end_test("inactive");
   endtask

   initial begin
      reset_s      = 1'b0;
      cmd_req      = 1'b0;
      cmd_frame    = '0;
      cmd_crc_good = 1'b0;
      resp_ack     = 1'b0;
      rca          = 16'h0;
      repeat (RESET_CYCLES) @(posedge clk_50);
      reset_s <= 1'b1;
      @(posedge clk_50);
      test_init();
      test_ident();
      test_select();
      test_error_cases();
      test_backpressure();
      test_inactive();
      $display("summary: %0d tests run, %0d errors, %0d assertion failures", tests_run,
               errors, sd_link_i.sd_link_chk_i.fail_count);
      if (errors == 0 && sd_link_i.sd_link_chk_i.fail_count == 0) begin
         $display("Result: PASSED");
      end else begin
         $display("Result: FAILED");
      end
      $finish;
   end

   // budget per command covers the longest ack delay and idle checks
   initial begin
      repeat (RESET_CYCLES + CMD_COUNT * CYCLE_BUDGET) @(posedge clk_50);
      $display("ERROR: watchdog expired after %0d cycles, a handshake is stuck", cycle);
      $display("Result: FAILED");
      $finish;
   end

endmodule

//--- source/sd_card_execute.sv
`timescale 1ns/10ps

module sd_card_execute import sd_link_pkg::*; (
   input  logic        clk_50,
   input  logic        reset_s,
   input  logic        op_valid,
   input  cmd_op_t     op,
   input  logic [5:0]  cmd_index,
   input  logic [31:0] cmd_arg,
   input  logic        crc_fail,
   input  logic        resp_done,
   input  logic        resp_idle,
   output logic        exec_ready,
   output logic        app_pending,
   output logic        resp_start,
   output resp_kind_t  resp_kind,
   output logic [5:0]  resp_index,
   output logic [31:0] card_status,
   output logic [15:0] card_rca,
   output logic [31:0] card_ocr,
   output logic [31:0] resp_echo,
   output card_state_t card_state
);

   card_state_t state_next;
   card_state_t next_c;
   resp_kind_t  kind_c;
   cmd_op_t     op_q;
   logic        busy;
   logic        rca_match;
   logic        stby_to_dis;

   assign rca_match   = (cmd_arg[31:16] == card_rca);
   assign stby_to_dis = (card_state >= CARD_STBY) && (card_state <= CARD_DIS);

   // one command in flight, wait for the phy to release resp_ack too
   assign exec_ready  = !busy && !op_valid && resp_idle;

   // response kind and target state for the current op
   always_comb begin
      kind_c = RESP_BAD;
      next_c = card_state;
      case (op)
         OP_GO_IDLE: begin
            kind_c = RESP_NONE;
            if (card_state != CARD_INA) begin
               next_c = CARD_IDLE;
            end
         end
         OP_SEND_IF_COND: begin
            kind_c = RESP_NONE;
            if (card_state == CARD_IDLE && cmd_arg[11:8] == 4'b0001) begin
               kind_c = RESP_R7;
            end
         end
         OP_APP_CMD: begin
            if (!rca_match) begin
               kind_c = RESP_NONE;
            end else if (card_state != CARD_INA) begin
               kind_c = RESP_R1;
            end
         end
         OP_APP_SEND_OP_COND: begin
            if (card_state == CARD_IDLE) begin
               kind_c = RESP_R3;
               next_c = CARD_READY;
            end
         end
         OP_ALL_SEND_CID: begin
            if (card_state == CARD_READY) begin
               kind_c = RESP_R2;
               next_c = CARD_IDENT;
            end
         end
         OP_SEND_REL_ADDR: begin
            if (card_state == CARD_IDENT || card_state == CARD_STBY) begin
               kind_c = RESP_R6;
               next_c = CARD_STBY;
            end
         end
         OP_SEL_CARD: begin
            if (rca_match && card_state == CARD_STBY) begin
               kind_c = RESP_R1B;
               next_c = CARD_TRAN;
            end else if (!rca_match &&
                         (card_state == CARD_TRAN || card_state == CARD_STBY)) begin
               // deselect
               kind_c = RESP_NONE;
               next_c = CARD_STBY;
            end
         end
         OP_SEND_STATUS: begin
            if (rca_match && stby_to_dis) begin
               kind_c = RESP_R1;
            end
         end
         OP_GO_INACTIVE: begin
            if (rca_match && stby_to_dis) begin
               kind_c = RESP_NONE;
               next_c = CARD_INA;
            end
         end
         default: kind_c = RESP_BAD;
      endcase
   end

   always_ff @(posedge clk_50) begin
      if (!reset_s) begin
         card_state  <= CARD_IDLE;
         card_rca    <= 16'h0;
         card_ocr    <= OCR_RESET;
         card_status <= STATUS_RESET;
         app_pending <= 1'b0;
         busy        <= 1'b0;
         resp_start  <= 1'b0;
      end else begin
         resp_start <= 1'b0;
         if (crc_fail) begin
            card_status[STAT_COM_CRC_ERROR] <= 1'b1;
         end
         if (op_valid) begin
            // status reports the state before the transition
            card_status[STAT_STATE_LSB +: 4] <= card_state;
            resp_kind  <= kind_c;
            resp_index <= cmd_index;
            resp_echo  <= {20'h0, 4'b0001, cmd_arg[7:0]};
            state_next <= next_c;
            op_q       <= op;
            if (kind_c == RESP_BAD) begin
               card_status[STAT_ILLEGAL_COMMAND] <= 1'b1;
            end else begin
               card_status[STAT_ILLEGAL_COMMAND] <= 1'b0;
               card_status[STAT_COM_CRC_ERROR]   <= 1'b0;
            end
            // a plain command after CMD55 drops the app prefix
            if (op != OP_APP_CMD && op != OP_APP_SEND_OP_COND) begin
               app_pending <= 1'b0;
            end
            if (kind_c == RESP_NONE || kind_c == RESP_BAD) begin
               // retire here, nothing to send
               card_state <= next_c;
               if (op == OP_APP_SEND_OP_COND) begin
                  app_pending                <= 1'b0;
                  card_status[STAT_APP_CMD] <= 1'b0;
               end
            end else begin
               resp_start <= 1'b1;
               busy       <= 1'b1;
            end
            if (op == OP_SEND_REL_ADDR && kind_c == RESP_R6) begin
               card_rca <= card_rca + RCA_STEP;
            end
            if (op == OP_APP_SEND_OP_COND && kind_c == RESP_R3) begin
               card_ocr[OCR_POWERED_UP] <= 1'b1;
            end
            if (op == OP_APP_CMD && kind_c == RESP_R1) begin
               app_pending                <= 1'b1;
               card_status[STAT_APP_CMD] <= 1'b1;
            end
            // go idle resets everything except in INA
            if (op == OP_GO_IDLE && card_state != CARD_INA) begin
               card_rca    <= 16'h0;
               card_ocr    <= OCR_RESET;
               card_status <= STATUS_RESET;
               app_pending <= 1'b0;
            end
         end
         if (resp_done) begin
            card_state <= state_next;
            busy       <= 1'b0;
            // app flag lasts for one ACMD only
            if (op_q == OP_APP_SEND_OP_COND) begin
               app_pending                <= 1'b0;
               card_status[STAT_APP_CMD] <= 1'b0;
            end
         end
      end
   end

endmodule

//--- source/sd_cmd_decode.sv
`timescale 1ns/10ps

module sd_cmd_decode import sd_link_pkg::*; (
   input  logic                   clk_50,
   input  logic                   reset_s,
   input  logic                   cmd_req,
   input  logic [CMD_FRAME_W-1:0] cmd_frame,
   input  logic                   cmd_crc_good,
   input  logic                   exec_ready,
   input  logic                   app_pending,
   output logic                   cmd_ack,
   output logic                   op_valid,
   output cmd_op_t                op,
   output logic [5:0]             cmd_index,
   output logic [31:0]            cmd_arg,
   output logic                   crc_fail,
   output logic                   err_cmd_crc,
   output logic                   err_unhandled_cmd
);

   logic [CMD_FRAME_W-1:0] frame_q;
   logic                   crc_q;
   logic                   latched;
   cmd_op_t                op_c;

   assign cmd_index = frame_q[CMD_INDEX_MSB:CMD_INDEX_LSB];
   assign cmd_arg   = frame_q[CMD_ARG_MSB:CMD_ARG_LSB];

   // index 41 is only an ACMD right after CMD55
   always_comb begin
      op_c = OP_UNKNOWN;
      case (cmd_index)
         CMD_IDX_GO_IDLE:       op_c = OP_GO_IDLE;
         CMD_IDX_ALL_SEND_CID:  op_c = OP_ALL_SEND_CID;
         CMD_IDX_SEND_REL_ADDR: op_c = OP_SEND_REL_ADDR;
         CMD_IDX_SEL_CARD:      op_c = OP_SEL_CARD;
         CMD_IDX_SEND_IF_COND:  op_c = OP_SEND_IF_COND;
         CMD_IDX_SEND_STATUS:   op_c = OP_SEND_STATUS;
         CMD_IDX_GO_INACTIVE:   op_c = OP_GO_INACTIVE;
         CMD_IDX_APP_CMD:       op_c = OP_APP_CMD;
         ACMD_IDX_SEND_OP_COND: begin
            if (app_pending) begin
               op_c = OP_APP_SEND_OP_COND;
            end
         end
         default:               op_c = OP_UNKNOWN;
      endcase
   end

   always_ff @(posedge clk_50) begin
      if (!reset_s) begin
         cmd_ack           <= 1'b0;
         latched           <= 1'b0;
         op_valid          <= 1'b0;
         crc_fail          <= 1'b0;
         err_cmd_crc       <= 1'b0;
         err_unhandled_cmd <= 1'b0;
      end else begin
         latched  <= 1'b0;
         op_valid <= 1'b0;
         crc_fail <= 1'b0;
         // four-phase handshake with the phy
         if (!cmd_ack && cmd_req && exec_ready) begin
            cmd_ack <= 1'b1;
            latched <= 1'b1;
            frame_q <= cmd_frame;
            crc_q   <= cmd_crc_good;
         end else if (cmd_ack && !cmd_req) begin
            cmd_ack <= 1'b0;
         end
         // one cycle after the latch, hand over or flag the crc
         if (latched) begin
            if (crc_q) begin
               op_valid <= 1'b1;
               op       <= op_c;
               if (op_c == OP_UNKNOWN) begin
                  err_unhandled_cmd <= 1'b1;
               end
            end else begin
               crc_fail    <= 1'b1;
               err_cmd_crc <= 1'b1;
            end
         end
      end
   end

endmodule

//--- source/sd_link.sv
`timescale 1ns/10ps

module sd_link import sd_link_pkg::*; (
   input  logic                    clk_50,
   input  logic                    reset_s,
   input  logic                    cmd_req,
   input  logic [CMD_FRAME_W-1:0]  cmd_frame,
   input  logic                    cmd_crc_good,
   input  logic                    resp_ack,
   output logic                    cmd_ack,
   output logic                    resp_req,
   output logic [RESP_FRAME_W-1:0] resp_frame,
   output resp_kind_t              resp_kind,
   output card_state_t             card_state,
   output logic                    err_cmd_crc,
   output logic                    err_unhandled_cmd
);

   logic        exec_ready;
   logic        app_pending;
   logic        op_valid;
   cmd_op_t     op;
   logic [5:0]  cmd_index;
   logic [31:0] cmd_arg;
   logic        crc_fail;
   logic        resp_start;
   resp_kind_t  exec_kind;
   logic [5:0]  resp_index;
   logic [31:0] card_status;
   logic [15:0] card_rca;
   logic [31:0] card_ocr;
   logic [31:0] resp_echo;
   logic        resp_done;
   logic        resp_idle;

   sd_cmd_decode sd_cmd_decode_i (
      .clk_50, .reset_s, .cmd_req, .cmd_frame, .cmd_crc_good, .exec_ready,
      .app_pending, .cmd_ack, .op_valid, .op, .cmd_index, .cmd_arg, .crc_fail,
      .err_cmd_crc, .err_unhandled_cmd
   );

   sd_card_execute sd_card_execute_i (
      .clk_50, .reset_s, .op_valid, .op, .cmd_index, .cmd_arg, .crc_fail,
      .resp_done, .resp_idle, .exec_ready, .app_pending, .resp_start,
      .resp_kind (exec_kind), .resp_index, .card_status, .card_rca, .card_ocr,
      .resp_echo, .card_state
   );

   sd_resp_format sd_resp_format_i (
      .clk_50, .reset_s, .resp_start, .resp_kind (exec_kind), .resp_index,
      .card_status, .card_rca, .card_ocr, .resp_echo, .resp_ack, .resp_req,
      .resp_frame, .resp_kind_out (resp_kind), .resp_done, .resp_idle
   );

endmodule

//--- source/sd_link_pkg.sv
package sd_link_pkg;

   // card states as reported in the status register
   typedef enum logic [3:0] {
      CARD_IDLE  = 4'd0,
      CARD_READY = 4'd1,
      CARD_IDENT = 4'd2,
      CARD_STBY  = 4'd3,
      CARD_TRAN  = 4'd4,
      CARD_DATA  = 4'd5,
      CARD_RCV   = 4'd6,
      CARD_PRG   = 4'd7,
      CARD_DIS   = 4'd8,
      CARD_INA   = 4'd9
   } card_state_t;

   // decoded operations, ACMDs only after CMD55
   typedef enum logic [3:0] {
      OP_GO_IDLE,
      OP_ALL_SEND_CID,
      OP_SEND_REL_ADDR,
      OP_SEL_CARD,
      OP_SEND_IF_COND,
      OP_SEND_STATUS,
      OP_GO_INACTIVE,
      OP_APP_CMD,
      OP_APP_SEND_OP_COND,
      OP_UNKNOWN
   } cmd_op_t;

   typedef enum logic [2:0] {
      RESP_NONE,
      RESP_BAD,
      RESP_R1,
      RESP_R1B,
      RESP_R2,
      RESP_R3,
      RESP_R6,
      RESP_R7
   } resp_kind_t;

   localparam int CMD_FRAME_W  = 48;
   localparam int RESP_FRAME_W = 136;

   // command frame fields
   localparam int CMD_INDEX_MSB = 45;
   localparam int CMD_INDEX_LSB = 40;
   localparam int CMD_ARG_MSB   = 39;
   localparam int CMD_ARG_LSB   = 8;

   localparam logic [5:0] CMD_IDX_GO_IDLE       = 6'd0;
   localparam logic [5:0] CMD_IDX_ALL_SEND_CID  = 6'd2;
   localparam logic [5:0] CMD_IDX_SEND_REL_ADDR = 6'd3;
   localparam logic [5:0] CMD_IDX_SEL_CARD      = 6'd7;
   localparam logic [5:0] CMD_IDX_SEND_IF_COND  = 6'd8;
   localparam logic [5:0] CMD_IDX_SEND_STATUS   = 6'd13;
   localparam logic [5:0] CMD_IDX_GO_INACTIVE   = 6'd15;
   localparam logic [5:0] CMD_IDX_APP_CMD       = 6'd55;
   localparam logic [5:0] ACMD_IDX_SEND_OP_COND = 6'd41;

   localparam logic [15:0] RCA_STEP = 16'h1337;

   // high capacity, voltage window, not yet powered up
   localparam logic [23:0] OCR_VOLTAGE_WINDOW = 24'hFF8000;
   localparam logic [31:0] OCR_RESET          = 32'h40FF8000;
   localparam int          OCR_POWERED_UP     = 31;

   // mid, oid, pnm, prv, psn, mdt, crc7 + stop bit
   localparam logic [127:0] CID_VALUE = 128'h0353_444C_4E4B_3031_1012_3456_7801_4B01;

   // card status bits
   localparam int STAT_COM_CRC_ERROR   = 23;
   localparam int STAT_ILLEGAL_COMMAND = 22;
   localparam int STAT_ERROR           = 19;
   localparam int STAT_STATE_LSB       = 9;
   localparam int STAT_READY_FOR_DATA  = 8;
   localparam int STAT_APP_CMD         = 5;

   localparam logic [31:0] STATUS_RESET = 32'd1 << STAT_READY_FOR_DATA;

endpackage

//--- source/sd_resp_format.sv
`timescale 1ns/10ps

module sd_resp_format import sd_link_pkg::*; (
   input  logic                    clk_50,
   input  logic                    reset_s,
   input  logic                    resp_start,
   input  resp_kind_t              resp_kind,
   input  logic [5:0]              resp_index,
   input  logic [31:0]             card_status,
   input  logic [15:0]             card_rca,
   input  logic [31:0]             card_ocr,
   input  logic [31:0]             resp_echo,
   input  logic                    resp_ack,
   output logic                    resp_req,
   output logic [RESP_FRAME_W-1:0] resp_frame,
   output resp_kind_t              resp_kind_out,
   output logic                    resp_done,
   output logic                    resp_idle
);

   logic [RESP_FRAME_W-1:0] frame_c;
   logic [15:0]             status_short;

   // R6 carries a compressed status
   assign status_short = {card_status[STAT_COM_CRC_ERROR],
                          card_status[STAT_ILLEGAL_COMMAND],
                          card_status[STAT_ERROR],
                          card_status[12:0]};

   // idle only once the phy has dropped its ack
   assign resp_idle = !resp_req && !resp_ack;

   always_comb begin
      frame_c = '0;
      case (resp_kind)
         RESP_R1, RESP_R1B: begin
            frame_c = {2'b00, resp_index, card_status, 8'h01, 88'h0};
         end
         RESP_R2: begin
            frame_c = {2'b00, 6'b111111, CID_VALUE[127:1], 1'b1};
         end
         RESP_R3: begin
            frame_c = {2'b00, 6'b111111, card_ocr, 8'hFF, 88'h0};
         end
         RESP_R6: begin
            frame_c = {2'b00, 6'd3, card_rca, status_short, 8'h01, 88'h0};
         end
         RESP_R7: begin
            frame_c = {2'b00, 6'd8, resp_echo, 8'h01, 88'h0};
         end
         default: frame_c = '0;
      endcase
   end

   always_ff @(posedge clk_50) begin
      if (!reset_s) begin
         resp_req      <= 1'b0;
         resp_done     <= 1'b0;
         resp_kind_out <= RESP_NONE;
      end else begin
         resp_done <= 1'b0;
         if (resp_start) begin
            resp_req      <= 1'b1;
            resp_frame    <= frame_c;
            resp_kind_out <= resp_kind;
         end else if (resp_req && resp_ack) begin
            // frame and kind hold until here
            resp_req  <= 1'b0;
            resp_done <= 1'b1;
         end
      end
   end

endmodule
